// File: include/sme_settings.svh
`ifndef SME_SETTINGS_SVH
`define SME_SETTINGS_SVH

// Share geometry ------------------------------

// Hardware shares per secret word, share 0 is in the GPRs
`define SME_SMAX 3

// Width of one share word
`define SME_XLEN 32

// Registers held in each share bank
`define SME_NREG 16

// Derived widths ------------------------------

`define SME_RADDR_W $clog2(`SME_NREG)              // Register address bits
`define SME_SHAMT_W $clog2(`SME_XLEN)              // Shift amount bits
`define SME_NPAIR (`SME_SMAX*(`SME_SMAX-1)/2)      // Share pairs for ISW AND
`define SME_RNG_W (`SME_XLEN*`SME_NPAIR)           // One fresh word per pair
`define SME_BSEL_W $clog2(`SME_SMAX)               // Bank select bits

`endif

// File: logic/sme_pkg.sv
`default_nettype none

`include "sme_settings.svh"

package sme_pkg;

  // Share storage ------------------------------

  typedef logic [`SME_XLEN-1:0] sme_word_t;          // One share of one word
  typedef sme_word_t [`SME_SMAX-1:0] sme_shares_t;   // Indexed by share number

  // Op word views ------------------------------

  typedef struct packed {
    logic op_xor;     // Share-wise XOR
    logic op_and;     // ISW masked AND
    logic op_not;     // Invert share 0 of rs2
    logic op_sll;     // Shift left by shamt
    logic op_srl;     // Shift right by shamt
    logic op_mask;    // Split rs1 share 0
    logic op_unmask;  // Fold to share 0
    logic spare;
  } sme_alu_op_t;

  typedef struct packed {
    logic       op_mix;     // AES MixColumn
    logic       op_invmix;  // AES inverse MixColumn
    logic       op_xrot;    // rs1 ^ rol(rs2, 8)
    logic [4:0] spare;
  } sme_cry_op_t;

  // Same 8 bits, meaning set by which strobe fires
  typedef union packed {
    sme_alu_op_t alu;
    sme_cry_op_t cry;
  } sme_op_u;

  // Multiply by x in GF(2^8), AES polynomial
  function automatic logic [7:0] sme_xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

`default_nettype wire

// File: logic/sme_regfile.sv
`default_nettype none
`timescale 1ns/100ps

`include "sme_settings.svh"

module sme_regfile (
  input  wire                          g_clk_i,      // Global clock
  input  wire                          rst_n_i,      // Sync reset, active low
  input  wire  [`SME_RADDR_W-1:0]      rs1_addr_i,   // Read port 1 address
  output sme_pkg::sme_word_t           rs1_rdata_o,  // Read port 1 data
  input  wire  [`SME_RADDR_W-1:0]      rs2_addr_i,   // Read port 2 address
  output sme_pkg::sme_word_t           rs2_rdata_o,  // Read port 2 data
  input  wire                          rd_wen_i,     // Write strobe
  input  wire  [`SME_RADDR_W-1:0]      rd_addr_i,    // Write address
  input  wire  sme_pkg::sme_word_t     rd_wdata_i    // Write data
);

  import sme_pkg::*;

  // Storage ------------------------------

  sme_word_t regs [`SME_NREG];                       // One share of every register

  always_ff @(posedge g_clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `SME_NREG; r++) begin
        regs[r] <= '0;                               // Whole bank reads zero
      end
    end else if (rd_wen_i) begin
      regs[rd_addr_i] <= rd_wdata_i;                 // Visible next cycle
    end
  end

  // Read ports ------------------------------

  assign rs1_rdata_o = regs[rs1_addr_i];             // Async read
  assign rs2_rdata_o = regs[rs2_addr_i];             // Async read

endmodule

`default_nettype wire

// File: logic/sme_alu.sv
`default_nettype none
`timescale 1ns/100ps

`include "sme_settings.svh"

module sme_alu (
  input  wire  sme_pkg::sme_shares_t   rs1_i,    // rs1 as all shares
  input  wire  sme_pkg::sme_shares_t   rs2_i,    // rs2 as all shares
  input  wire  sme_pkg::sme_alu_op_t   op_i,     // One-hot op
  input  wire  [`SME_SHAMT_W-1:0]      shamt_i,  // Shift amount
  input  wire  [`SME_RNG_W-1:0]        rng_i,    // Fresh randomness
  output sme_pkg::sme_shares_t         rd_o      // rd as all shares
);

  import sme_pkg::*;

  sme_shares_t and_rd;                           // ISW AND result
  sme_shares_t mask_rd;                          // Freshly split rs1
  sme_word_t   fold;                             // XOR of all rs1 shares

  // ISW AND ------------------------------

  always_comb begin : isw_and
    sme_word_t z;
    int        k;
    and_rd = '0;
    k = 0;
    for (int i = 0; i < `SME_SMAX; i++) begin
      and_rd[i] = rs1_i[i] & rs2_i[i];           // Diagonal terms
    end
    for (int i = 0; i < `SME_SMAX; i++) begin
      for (int j = i + 1; j < `SME_SMAX; j++) begin
        z = rng_i[k*`SME_XLEN +: `SME_XLEN];     // One word per pair
        and_rd[i] = and_rd[i] ^ z;
        // Bracketing keeps z on the cross terms before they meet
        and_rd[j] = and_rd[j] ^ ((z ^ (rs1_i[i] & rs2_i[j])) ^ (rs1_i[j] & rs2_i[i]));
        k = k + 1;
      end
    end
  end

  // Mask / unmask ------------------------------

  always_comb begin : mask_fold
    mask_rd    = '0;
    mask_rd[0] = rs1_i[0];                       // Plain value in share 0
    fold       = '0;
    for (int i = 1; i < `SME_SMAX; i++) begin
      mask_rd[i] = rng_i[(i-1)*`SME_XLEN +: `SME_XLEN];
      mask_rd[0] = mask_rd[0] ^ mask_rd[i];      // Cancel each random share
    end
    for (int i = 0; i < `SME_SMAX; i++) begin
      fold = fold ^ rs1_i[i];                    // Reconstructed rs1
    end
  end

  // Result select ------------------------------

  always_comb begin : result_mux
    rd_o = '0;                                   // No op, no data
    if (op_i.op_xor) begin
      rd_o = rs1_i ^ rs2_i;                      // Linear, share by share
    end else if (op_i.op_and) begin
      rd_o = and_rd;
    end else if (op_i.op_not) begin
      rd_o    = rs2_i;
      rd_o[0] = ~rs2_i[0];                       // One inversion flips the value
    end else if (op_i.op_sll) begin
      for (int i = 0; i < `SME_SMAX; i++) begin
        rd_o[i] = rs1_i[i] << shamt_i;
      end
    end else if (op_i.op_srl) begin
      for (int i = 0; i < `SME_SMAX; i++) begin
        rd_o[i] = rs1_i[i] >> shamt_i;
      end
    end else if (op_i.op_mask) begin
      rd_o = mask_rd;
    end else if (op_i.op_unmask) begin
      rd_o[0] = fold;                            // Upper shares stay zero
    end
  end

endmodule

`default_nettype wire

// File: logic/sme_crypto.sv
`default_nettype none
`timescale 1ns/100ps

`include "sme_settings.svh"

module sme_crypto (
  input  wire  sme_pkg::sme_shares_t   rs1_i,  // rs1 as all shares
  input  wire  sme_pkg::sme_shares_t   rs2_i,  // rs2 as all shares
  input  wire  sme_pkg::sme_cry_op_t   op_i,   // One-hot op
  output sme_pkg::sme_shares_t         rd_o    // rd as all shares
);

  import sme_pkg::*;

  // Column transforms ------------------------------

  // Byte 0 in the low bits of the word
  function automatic sme_word_t mix_col(input sme_word_t w);
    logic [7:0] b0, b1, b2, b3, t;
    b0 = w[7:0];
    b1 = w[15:8];
    b2 = w[23:16];
    b3 = w[31:24];
    t  = b0 ^ b1 ^ b2 ^ b3;                    // Shared by all rows
    return {b3 ^ t ^ sme_xtime(b3 ^ b0),
            b2 ^ t ^ sme_xtime(b2 ^ b3),
            b1 ^ t ^ sme_xtime(b1 ^ b2),
            b0 ^ t ^ sme_xtime(b0 ^ b1)};
  endfunction

  // Inverse as a cheap pre-step then forward
  function automatic sme_word_t inv_mix_col(input sme_word_t w);
    logic [7:0] u, v;
    u = sme_xtime(sme_xtime(w[7:0] ^ w[23:16]));   // 4*(b0^b2)
    v = sme_xtime(sme_xtime(w[15:8] ^ w[31:24]));  // 4*(b1^b3)
    return mix_col(w ^ {v, u, v, u});
  endfunction

  // Share-wise datapath ------------------------------

  always_comb begin : cry_core
    rd_o = '0;                                 // No op, no data
    for (int i = 0; i < `SME_SMAX; i++) begin
      if (op_i.op_mix) begin
        rd_o[i] = mix_col(rs1_i[i]);           // Linear over XOR
      end else if (op_i.op_invmix) begin
        rd_o[i] = inv_mix_col(rs1_i[i]);
      end else if (op_i.op_xrot) begin
        rd_o[i] = rs1_i[i] ^ {rs2_i[i][`SME_XLEN-9:0], rs2_i[i][`SME_XLEN-1 -: 8]};
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sme_state.sv
`default_nettype none
`timescale 1ns/100ps

`include "sme_settings.svh"

module sme_state (
  input  wire                          g_clk_i,       // Global clock
  input  wire                          rst_n_i,       // Sync reset, active low
  input  wire  sme_pkg::sme_word_t     rs1_rdata_i,   // rs1 share 0 from GPRs
  input  wire  sme_pkg::sme_word_t     rs2_rdata_i,   // rs2 share 0 from GPRs
  input  wire  [`SME_RADDR_W-1:0]      rs1_addr_i,
  input  wire  [`SME_RADDR_W-1:0]      rs2_addr_i,    // Also the bank read address
  input  wire  [`SME_RADDR_W-1:0]      rd_addr_i,
  input  wire  [`SME_SHAMT_W-1:0]      shamt_i,
  input  wire  [`SME_RNG_W-1:0]        rng_i,         // Fresh randomness
  input  wire  sme_pkg::sme_op_u       op_i,          // ALU or crypto view
  input  wire                          alu_valid_i,   // ALU op this cycle
  input  wire                          cry_valid_i,   // Crypto op this cycle
  input  wire                          bank_wen_i,    // Bank store
  input  wire  [`SME_RADDR_W-1:0]      bank_waddr_i,
  input  wire  sme_pkg::sme_word_t     bank_wdata_i,
  input  wire  [`SME_BSEL_W-1:0]       bank_sel_i,    // Share bank for load/store
  output sme_pkg::sme_word_t           alu_result_o,  // ALU rd share 0
  output sme_pkg::sme_word_t           cry_result_o,  // Crypto rd share 0
  output sme_pkg::sme_word_t           bank_rdata_o   // Share bank_sel of rs2
);

  import sme_pkg::*;

  localparam int unsigned BSEL_W = `SME_BSEL_W;

  wire sme_shares_t rs1_sh;                          // Share 0 port, rest banks
  wire sme_shares_t rs2_sh;
  sme_shares_t      alu_rd;
  sme_shares_t      cry_rd;
  sme_shares_t      res_rd;                          // Write-back candidate
  sme_alu_op_t      alu_op;
  sme_cry_op_t      cry_op;
  logic             res_wen;

  // Op decode ------------------------------

  assign alu_op = alu_valid_i ? op_i.alu : '0;       // Idle unit sees no op
  assign cry_op = cry_valid_i ? op_i.cry : '0;

  assign rs1_sh[0] = rs1_rdata_i;
  assign rs2_sh[0] = rs2_rdata_i;

  // Units ------------------------------

  sme_alu alu_i (
    .rs1_i   (rs1_sh),
    .rs2_i   (rs2_sh),
    .op_i    (alu_op),
    .shamt_i (shamt_i),
    .rng_i   (rng_i),
    .rd_o    (alu_rd)
  );

  sme_crypto crypto_i (
    .rs1_i (rs1_sh),
    .rs2_i (rs2_sh),
    .op_i  (cry_op),
    .rd_o  (cry_rd)
  );

  assign alu_result_o = alu_rd[0];                   // Share 0 back to GPRs
  assign cry_result_o = cry_rd[0];

  assign res_wen = alu_valid_i || cry_valid_i;
  assign res_rd  = alu_valid_i ? alu_rd : cry_rd;    // Strobes never overlap

  // Bank read guards selects past the last share
  assign bank_rdata_o = (int'(bank_sel_i) < `SME_SMAX) ? rs2_sh[bank_sel_i] : '0;

  // Share banks ------------------------------

  for (genvar b = 1; b < `SME_SMAX; b++) begin : gen_bank
    logic                     bank_hit;              // Store aimed at this bank
    logic                     rf_wen;
    logic [`SME_RADDR_W-1:0]  rf_addr;
    sme_word_t                rf_wdata;

    assign bank_hit = bank_wen_i && (bank_sel_i == BSEL_W'(b));
    // Any bank store blocks result writes in every bank
    assign rf_wen   = rst_n_i && (bank_wen_i ? bank_hit : res_wen);
    assign rf_addr  = bank_wen_i ? bank_waddr_i : rd_addr_i;
    assign rf_wdata = bank_wen_i ? bank_wdata_i : res_rd[b];

    sme_regfile rf_i (
      .g_clk_i     (g_clk_i),
      .rst_n_i     (rst_n_i),
      .rs1_addr_i  (rs1_addr_i),
      .rs1_rdata_o (rs1_sh[b]),
      .rs2_addr_i  (rs2_addr_i),
      .rs2_rdata_o (rs2_sh[b]),
      .rd_wen_i    (rf_wen),
      .rd_addr_i   (rf_addr),
      .rd_wdata_i  (rf_wdata)
    );
  end

endmodule

`default_nettype wire

// File: tests/sme_state_assert.sv
`default_nettype none
`timescale 1ns/100ps

`include "sme_settings.svh"

module sme_state_assert (
  input wire                    g_clk_i,
  input wire                    rst_n_i,
  input wire                    alu_valid_i,
  input wire                    cry_valid_i,
  input wire                    bank_wen_i,
  input wire [`SME_BSEL_W-1:0]  bank_sel_i,
  input wire [`SME_SMAX-1:1]    rf_wen_i      // Write strobe of each share bank
);

  // Strobes ------------------------------

  strobe_excl: assert property (@(posedge g_clk_i) !(alu_valid_i && cry_valid_i))
    else $error("alu_valid_i and cry_valid_i high in the same cycle");

  // Reset ------------------------------

  rst_quiet: assert property (@(posedge g_clk_i) !rst_n_i |-> (rf_wen_i == '0))
    else $error("share bank write enable high during reset");

  // Bank port ------------------------------

  bank0_store: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
                                bank_wen_i |-> (bank_sel_i != '0))
    else $error("bank store aimed at share 0");   // Share 0 is external

endmodule

`default_nettype wire

// File: tests/sme_state_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "sme_settings.svh"

module sme_state_tb;

  import sme_pkg::*;

  localparam int PERIOD     = 40;                   // Clock period in ns
  localparam int RST_CYCLES = 5;
  localparam int RADDR_W    = `SME_RADDR_W;
  localparam int BSEL_W     = `SME_BSEL_W;

  typedef struct {
    logic [7:0]          kind;                      // W, G, A or C
    sme_op_u             op;
    logic [RADDR_W-1:0]  rs1;
    logic [RADDR_W-1:0]  rs2;
    logic [RADDR_W-1:0]  rd;                        // Also the bank write address
    logic [`SME_SHAMT_W-1:0] shamt;
    logic [BSEL_W-1:0]   sel;
    sme_word_t           data;
    sme_word_t           exp_val;                   // Rebuilt rd value
  } rec_t;

  logic                    g_clk, rst_n, alu_valid, cry_valid, bank_wen;
  logic [RADDR_W-1:0]      rs1_addr, rs2_addr, rd_addr, bank_waddr;
  logic [`SME_SHAMT_W-1:0] shamt;
  logic [`SME_RNG_W-1:0]   rng;
  logic [BSEL_W-1:0]       bank_sel;
  sme_op_u                 op;
  sme_word_t               rs1_rdata, rs2_rdata, bank_wdata;
  sme_word_t               alu_result, cry_result, bank_rdata;
  sme_word_t               gpr [`SME_NREG];         // Share 0 lives in the GPRs
  rec_t                    recs [$];
  int                      seed = 32'h05f7_81a8;
  int                      n_err, n_pass, n_fail;
  bit                      loaded, ok;

  sme_state dut_i (
    .g_clk_i (g_clk), .rst_n_i (rst_n),
    .rs1_rdata_i (rs1_rdata), .rs2_rdata_i (rs2_rdata),
    .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr), .rd_addr_i (rd_addr),
    .shamt_i (shamt), .rng_i (rng), .op_i (op),
    .alu_valid_i (alu_valid), .cry_valid_i (cry_valid),
    .bank_wen_i (bank_wen), .bank_waddr_i (bank_waddr),
    .bank_wdata_i (bank_wdata), .bank_sel_i (bank_sel),
    .alu_result_o (alu_result), .cry_result_o (cry_result), .bank_rdata_o (bank_rdata)
  );

  // Two share banks at the default share count
  bind sme_state sme_state_assert assert_i (
    .g_clk_i (g_clk_i), .rst_n_i (rst_n_i), .alu_valid_i (alu_valid_i),
    .cry_valid_i (cry_valid_i), .bank_wen_i (bank_wen_i), .bank_sel_i (bank_sel_i),
    .rf_wen_i ({gen_bank[2].rf_wen, gen_bank[1].rf_wen})
  );

  always #(PERIOD/2) g_clk = ~g_clk;

  // Checks ------------------------------

  task automatic compare_word(input string name, input sme_word_t got, input sme_word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      n_err++;
    end
  endtask

  task automatic compare_shares(input string name, input sme_shares_t got,
                                input sme_shares_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      n_err++;
    end
  endtask

  task automatic finish_test(input string desc, input int err0);
    if (n_err == err0) begin
      n_pass++;
      $display("%s: pass", desc);
    end else begin
      n_fail++;
      $display("%s: FAIL", desc);
    end
  endtask

  // Drivers ------------------------------

  task automatic drive_idle();
    alu_valid = 1'b0;
    cry_valid = 1'b0;
    bank_wen  = 1'b0;
    op        = '0;
  endtask

  // Shares 1 and up of one register, one bank per cycle
  task automatic read_bank_shares(input logic [RADDR_W-1:0] addr, output sme_shares_t sh);
    sh = '0;
    for (int b = 1; b < `SME_SMAX; b++) begin
      @(posedge g_clk);
      #5;
      drive_idle();
      rs2_addr = addr;                              // Bank read follows rs2
      bank_sel = BSEL_W'(b);
      @(negedge g_clk);
      sh[b] = bank_rdata;
    end
  endtask

  task automatic write_bank(input rec_t r);
    @(posedge g_clk);
    #5;
    drive_idle();
    bank_wen   = 1'b1;                              // Lands on the next edge
    bank_waddr = r.rd;
    bank_sel   = r.sel;
    bank_wdata = r.data;
  endtask

  // Fill every bank, then reset with a store and an op still driven
  task automatic reset_filled_banks();
    for (int b = 1; b < `SME_SMAX; b++) begin
      for (int a = 0; a < `SME_NREG; a++) begin
        @(posedge g_clk);
        #5;
        drive_idle();
        bank_wen   = 1'b1;
        bank_waddr = RADDR_W'(a);
        bank_sel   = BSEL_W'(b);
        bank_wdata = {8'(b), 8'(a), ~8'(a), 8'h3c};   // Unique per bank and address
      end
    end
    @(posedge g_clk);
    #5;
    rst_n         = 1'b0;                           // Last store still held
    alu_valid     = 1'b1;
    op.alu.op_xor = 1'b1;
    repeat (RST_CYCLES) @(posedge g_clk);
    #5;
    drive_idle();
    rst_n = 1'b1;
  endtask

  task automatic run_op(input rec_t r);
    sme_shares_t got;
    sme_shares_t exp_sh;
    sme_word_t   res0;
    sme_word_t   recon;
    int          err0;
    err0 = n_err;
    @(posedge g_clk);
    #5;
    drive_idle();
    rs1_addr  = r.rs1;
    rs2_addr  = r.rs2;
    rd_addr   = r.rd;
    shamt     = r.shamt;
    rs1_rdata = gpr[r.rs1];
    rs2_rdata = gpr[r.rs2];
    for (int k = 0; k < `SME_NPAIR; k++) begin
      rng[k*`SME_XLEN +: `SME_XLEN] = $random(seed);  // Fresh mask words
    end
    op        = r.op;
    alu_valid = (r.kind == "A");
    cry_valid = (r.kind == "C");
    @(negedge g_clk);
    res0 = alu_valid ? alu_result : cry_result;     // Share 0 only on the port
    read_bank_shares(r.rd, got);
    got[0] = res0;
    recon  = '0;
    for (int s = 0; s < `SME_SMAX; s++) begin
      recon = recon ^ got[s];
    end
    compare_word($sformatf("r%0d rebuilt", r.rd), recon, r.exp_val);
    if (r.kind == "A" && r.op.alu.op_unmask) begin
      exp_sh    = '0;                               // Only share 0 survives
      exp_sh[0] = r.exp_val;
      compare_shares($sformatf("r%0d shares", r.rd), got, exp_sh);
    end
    gpr[r.rd] = res0;
    finish_test($sformatf("test %0d %c op %h rd r%0d", n_pass + n_fail + 1, r.kind,
                          r.op, r.rd), err0);
  endtask

  task automatic check_reset_clear();
    sme_shares_t sh;
    int          err0;
    err0 = n_err;
    for (int a = 0; a < `SME_NREG; a++) begin
      read_bank_shares(RADDR_W'(a), sh);
      compare_shares($sformatf("bank shares of r%0d", a), sh, '0);
    end
    finish_test("reset clears every bank", err0);
  endtask

  // Stimulus ------------------------------

  task automatic load_stim(output bit opened);
    int         fd;
    string      line;
    rec_t       r;
    logic [7:0] op_raw;
    fd     = $fopen("tests/sme_stim.txt", "r");
    opened = (fd != 0);
    if (opened) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin  // Skip blanks and column notes
          if ($sscanf(line, "%c %h %h %h %h %h %h %h %h", r.kind, op_raw, r.rs1, r.rs2,
                      r.rd, r.shamt, r.sel, r.data, r.exp_val) == 9) begin
            r.op = op_raw;
            recs.push_back(r);
          end else begin
            $display("Malformed stimulus line: %s", line);
            n_fail++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = (recs.size() * 20 + 2 * RST_CYCLES + 2 * `SME_NREG * `SME_SMAX) * PERIOD;
    #(limit);
    $display("Timeout: run still busy after %0d ns", limit);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    g_clk      = 1'b0;
    rst_n      = 1'b0;
    rs1_rdata  = '0;
    rs2_rdata  = '0;
    rs1_addr   = '0;
    rs2_addr   = '0;
    rd_addr    = '0;
    shamt      = '0;
    rng        = '0;
    bank_waddr = '0;
    bank_wdata = '0;
    bank_sel   = '0;
    drive_idle();
    for (int i = 0; i < `SME_NREG; i++) begin
      gpr[i] = '0;
    end
    load_stim(ok);
    if (!ok) begin
      $display("Could not open stimulus file tests/sme_stim.txt");
      n_fail++;
    end else begin
      loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge g_clk);
      #5;
      rst_n = 1'b1;
      reset_filled_banks();
      check_reset_clear();
      foreach (recs[i]) begin
        case (recs[i].kind)
          "W":     write_bank(recs[i]);
          "G":     gpr[recs[i].rd] = recs[i].data;  // GPR share 0, no DUT traffic
          default: run_op(recs[i]);
        endcase
      end
      @(posedge g_clk);
      #5;
      drive_idle();
    end
    $display("Tests %0d, passed %0d, failed %0d, check errors %0d",
             n_pass + n_fail, n_pass, n_fail, n_err);
    if (n_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/sme_stim.txt
# kind op rs1 rs2 rd shamt sel data expect, all hex; W stores data in bank sel of rd,
# G sets GPR share 0 of rd, A and C run an op and expect the rebuilt value of rd
W 00 0 0 1 00 1 11111111 00000000
W 00 0 0 1 00 2 22222222 00000000
G 00 0 0 1 00 0 766020e8 00000000
W 00 0 0 2 00 1 0f0f0f0f 00000000
W 00 0 0 2 00 2 f0f0f0f0 00000000
G 00 0 0 2 00 0 a3ddf50d 00000000
A 80 1 2 3 00 0 00000000 19711929
C 20 1 2 4 00 0 00000000 6759e187
A 40 1 2 5 00 0 00000000 440202d2
A 40 1 2 5 00 0 00000000 440202d2
A 20 1 2 6 00 0 00000000 a3ddf50d
C 80 1 0 7 00 0 00000000 bca14d8e
C 40 7 0 8 00 0 00000000 455313db
C 80 2 0 9 00 0 00000000 9d58dc9f
A 10 1 0 a 04 0 00000000 55313db0
A 10 1 0 a 1f 0 00000000 80000000
A 08 2 0 b 08 0 00000000 005c220a
A 40 3 4 f 00 0 00000000 01510101
G 00 0 0 c 00 0 13579bdf 00000000
A 04 c 0 d 00 0 00000000 13579bdf
A 02 d 0 e 00 0 00000000 13579bdf
A 80 8 1 3 00 0 00000000 00000000

// File: tb.f
+incdir+include
logic/sme_pkg.sv
logic/sme_regfile.sv
logic/sme_alu.sv
logic/sme_crypto.sv
logic/sme_state.sv
tests/sme_state_assert.sv
tests/sme_state_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the sme_state testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sme_state_tb -Mdir obj_dir -f tb.f \
  && ./obj_dir/Vsme_state_tb | tee /dev/stderr | grep -x "All tests passed" > /dev/null \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }
